//--- common/cgra_cfg.svh
// ------------------------------------------------------------
// Build-time sizes and host register map of the CGRA subsystem
// Include wherever array geometry or register indices are needed
// ------------------------------------------------------------
`ifndef CGRA_CFG_SVH
`define CGRA_CFG_SVH

// Array geometry
`define CGRA_N_COL        4
`define CGRA_N_LINES      16

// Datapath and instruction immediate
`define CGRA_DP_WIDTH     32
`define CGRA_IMM_WIDTH    8

// Host register word indices
`define CGRA_REG_CTRL     0
`define CGRA_REG_STATUS   1
// Accumulator c sits at word ACC_BASE + c
`define CGRA_REG_ACC_BASE 4

`endif

//--- common/cgra_pkg.sv
// ------------------------------------------------------------
// Shared types of the CGRA subsystem: datapath words, context
// words and lines, opcodes, FSM states and the register port
// ------------------------------------------------------------
`include "cgra_cfg.svh"

package cgra_pkg;

  typedef logic [`CGRA_DP_WIDTH-1:0]          dp_word_t;
  typedef logic [`CGRA_IMM_WIDTH-1:0]         imm_t;
  typedef logic [$clog2(`CGRA_N_LINES)-1:0]   line_idx_t;
  typedef logic [$clog2(`CGRA_N_COL)-1:0]     col_idx_t;
  // Context word address is {line, column}
  typedef logic [$bits(line_idx_t)+$bits(col_idx_t)-1:0] cm_addr_t;
  typedef logic [7:0]                         reg_addr_t;

  typedef enum logic [2:0] {
    RC_NOP  = 3'd0,
    RC_LDI  = 3'd1,
    RC_ADDI = 3'd2,
    RC_SUBI = 3'd3,
    RC_MULI = 3'd4,
    RC_SHLI = 3'd5,
    RC_ADDN = 3'd6,
    RC_END  = 3'd7
  } rc_op_e;

  // Opcode in the upper bits, immediate below
  typedef logic [$bits(rc_op_e)+`CGRA_IMM_WIDTH-1:0] ctx_word_t;
  typedef ctx_word_t [`CGRA_N_COL-1:0]               ctx_line_t;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_FETCH,
    CTRL_EXEC,
    CTRL_DONE
  } ctrl_state_e;

  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    dp_word_t  wdata;
  } reg_req_t;

  typedef struct packed {
    logic     ready;
    dp_word_t rdata;
  } reg_rsp_t;

  function automatic rc_op_e ctx_op(ctx_word_t word);
    return rc_op_e'(word[`CGRA_IMM_WIDTH +: $bits(rc_op_e)]);
  endfunction

  function automatic imm_t ctx_imm(ctx_word_t word);
    return word[`CGRA_IMM_WIDTH-1:0];
  endfunction

endpackage

//--- rtl/cgra_pc_counter.sv
// ------------------------------------------------------------
// Fetch line counter, loaded with the start line and advanced
// per fetch; flags a fetch beyond the final memory line
// ------------------------------------------------------------
`timescale 1ns/10ps
`include "cgra_cfg.svh"

module cgra_pc_counter
  import cgra_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      load_i,
  input  line_idx_t line_i,
  input  logic      adv_i,
  output line_idx_t line_o,
  output logic      last_o
);

  line_idx_t line_q;
  logic      wrap_q;
  logic      last_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_q <= '0;
      wrap_q <= 1'b0;
      last_q <= 1'b0;
    end else if (load_i) begin
      line_q <= line_i;
      wrap_q <= 1'b0;
      last_q <= 1'b0;
    end else if (adv_i) begin
      line_q <= line_q + 1'b1;
      // Set once the final line has been fetched
      wrap_q <= wrap_q || (line_q == line_idx_t'(`CGRA_N_LINES - 1));
      // Lags by one fetch so it lines up with the memory read data
      last_q <= wrap_q;
    end
  end

  assign line_o = line_q;
  assign last_o = last_q;

endmodule

//--- rtl/cgra_controller.sv
// ------------------------------------------------------------
// Kernel FSM: fetches context lines one ahead of execution and
// stops on a column-0 END or after the final memory line
// ------------------------------------------------------------
`timescale 1ns/10ps

module cgra_controller
  import cgra_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start_i,
  input  line_idx_t start_line_i,
  input  ctx_line_t line_i,
  input  logic      last_line_i,
  output logic      cnt_load_o,
  output line_idx_t cnt_line_o,
  output logic      cnt_adv_o,
  output logic      line_re_o,
  output logic      exec_en_o,
  output logic      busy_o,
  output logic      done_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        line_end;
  logic        line_run;

  // Line returned this cycle terminates the kernel
  assign line_end = (ctx_op(line_i[0]) == RC_END) || last_line_i;
  assign line_run = (state_q == CTRL_EXEC) && !line_end;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CTRL_IDLE: begin
        if (start_i) begin
          state_d = CTRL_FETCH;
        end
      end
      CTRL_FETCH: begin
        state_d = CTRL_EXEC;
      end
      CTRL_EXEC: begin
        if (line_end) begin
          state_d = CTRL_DONE;
        end
      end
      CTRL_DONE: begin
        // A new start may already arrive in the done cycle
        state_d = start_i ? CTRL_FETCH : CTRL_IDLE;
      end
      default: begin
        state_d = CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign busy_o = (state_q == CTRL_FETCH) || (state_q == CTRL_EXEC);
  assign done_o = state_q == CTRL_DONE;

  // Counter load with the requested first line
  assign cnt_load_o = start_i && !busy_o;
  assign cnt_line_o = start_line_i;

  // Next line is fetched while the current one executes
  assign line_re_o = (state_q == CTRL_FETCH) || line_run;
  assign cnt_adv_o = line_re_o;
  assign exec_en_o = line_run;

endmodule

//--- rtl/cgra_synchronizer.sv
// ------------------------------------------------------------
// Host register block: decodes CTRL, STATUS and accumulator
// words, issues the kernel start and raises the end event
// ------------------------------------------------------------
`timescale 1ns/10ps
`include "cgra_cfg.svh"

module cgra_synchronizer
  import cgra_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  reg_req_t                   reg_req_i,
  output reg_rsp_t                   reg_rsp_o,
  input  logic                       busy_i,
  input  logic                       done_i,
  input  dp_word_t [`CGRA_N_COL-1:0] acc_i,
  output logic                       start_o,
  output line_idx_t                  start_line_o,
  output logic                       acc_we_o,
  output col_idx_t                   acc_col_o,
  output dp_word_t                   acc_wdata_o,
  output logic                       evt_o
);

  logic      ready;
  logic      wr_fire;
  logic      ctrl_sel;
  logic      status_sel;
  logic      acc_sel;
  reg_addr_t acc_off;
  logic      done_q;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------

  assign ctrl_sel   = reg_req_i.addr == reg_addr_t'(`CGRA_REG_CTRL);
  assign status_sel = reg_req_i.addr == reg_addr_t'(`CGRA_REG_STATUS);
  // Offset wraps for addresses below the base, so one compare covers the range
  assign acc_off    = reg_req_i.addr - reg_addr_t'(`CGRA_REG_ACC_BASE);
  assign acc_sel    = acc_off < reg_addr_t'(`CGRA_N_COL);

  // Writes stall while a kernel runs, reads never do
  assign ready   = !(reg_req_i.write && busy_i);
  assign wr_fire = reg_req_i.valid && reg_req_i.write && ready;

  // Start pulse in the cycle the CTRL write is accepted
  assign start_o      = wr_fire && ctrl_sel && reg_req_i.wdata[0];
  assign start_line_o = reg_req_i.wdata[4 +: $bits(line_idx_t)];

  // Direct accumulator load
  assign acc_we_o    = wr_fire && acc_sel;
  assign acc_col_o   = acc_off[$bits(col_idx_t)-1:0];
  assign acc_wdata_o = reg_req_i.wdata;

  // Sticky done, cleared by the next start
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (start_o) begin
      done_q <= 1'b0;
    end else if (done_i) begin
      done_q <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Read data
  // ------------------------------------------------------------

  always_comb begin
    reg_rsp_o.ready = ready;
    reg_rsp_o.rdata = '0;
    if (status_sel) begin
      // Done shows already in the cycle of the done pulse
      reg_rsp_o.rdata[0] = busy_i;
      reg_rsp_o.rdata[1] = done_q || done_i;
    end else if (acc_sel) begin
      reg_rsp_o.rdata = acc_i[acc_off[$bits(col_idx_t)-1:0]];
    end
  end

  assign evt_o = done_i;

endmodule

//--- rtl/context_memory/context_memory_decoder.sv
// ------------------------------------------------------------
// Context memory: host word access while idle, full-line reads
// for the controller, both with one cycle of latency
// ------------------------------------------------------------
`timescale 1ns/10ps
`include "cgra_cfg.svh"

module context_memory_decoder
  import cgra_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Host word port
  input  logic      cm_req_i,
  input  logic      cm_we_i,
  input  cm_addr_t  cm_add_i,
  input  ctx_word_t cm_wdata_i,
  output logic      cm_gnt_o,
  output logic      cm_rvalid_o,
  output ctx_word_t cm_rdata_o,
  // Controller line port
  input  logic      busy_i,
  input  logic      line_re_i,
  input  line_idx_t line_addr_i,
  output ctx_line_t line_o
);

  ctx_line_t mem_q [`CGRA_N_LINES];
  line_idx_t host_line;
  col_idx_t  host_col;
  logic      host_wr;
  logic      host_rd;

  assign {host_line, host_col} = cm_add_i;

  // Host only gets the memory while no kernel runs
  assign cm_gnt_o = cm_req_i && !busy_i;
  assign host_wr  = cm_gnt_o && cm_we_i;
  assign host_rd  = cm_gnt_o && !cm_we_i;

  always_ff @(posedge clk_i) begin
    if (host_wr) begin
      mem_q[host_line][host_col] <= cm_wdata_i;
    end
    if (host_rd) begin
      cm_rdata_o <= mem_q[host_line][host_col];
    end
    if (line_re_i) begin
      line_o <= mem_q[line_addr_i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cm_rvalid_o <= 1'b0;
    end else begin
      cm_rvalid_o <= host_rd;
    end
  end

endmodule

//--- rtl/cgra_rcs/reconfigurable_cell.sv
// ------------------------------------------------------------
// Single reconfigurable cell: decodes one instruction word and
// updates its accumulator on each executed line
// ------------------------------------------------------------
`timescale 1ns/10ps

module reconfigurable_cell
  import cgra_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ctx_word_t instr_i,
  input  logic      exec_en_i,
  input  dp_word_t  nbr_acc_i,
  input  logic      load_i,
  input  dp_word_t  load_data_i,
  output dp_word_t  acc_o
);

  rc_op_e   op;
  dp_word_t imm;
  dp_word_t acc_q;
  dp_word_t acc_d;

  assign op  = ctx_op(instr_i);
  // Immediate is zero-extended
  assign imm = dp_word_t'(ctx_imm(instr_i));

  always_comb begin
    unique case (op)
      RC_LDI:  acc_d = imm;
      RC_ADDI: acc_d = acc_q + imm;
      RC_SUBI: acc_d = acc_q - imm;
      RC_MULI: acc_d = acc_q * imm;
      RC_SHLI: acc_d = acc_q << imm[4:0];
      // Neighbour value as registered at the start of this line
      RC_ADDN: acc_d = acc_q + nbr_acc_i;
      default: acc_d = acc_q;
    endcase
  end

  // Host load has priority over execution
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (load_i) begin
      acc_q <= load_data_i;
    end else if (exec_en_i) begin
      acc_q <= acc_d;
    end
  end

  assign acc_o = acc_q;

endmodule

//--- rtl/cgra_rcs/cgra_rcs.sv
// ------------------------------------------------------------
// Cell array: one cell per column, joined in a ring through
// their accumulators; host loads go to a single column
// ------------------------------------------------------------
`timescale 1ns/10ps
`include "cgra_cfg.svh"

module cgra_rcs
  import cgra_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  ctx_line_t                  line_i,
  input  logic                       exec_en_i,
  input  logic                       acc_we_i,
  input  col_idx_t                   acc_col_i,
  input  dp_word_t                   acc_wdata_i,
  output dp_word_t [`CGRA_N_COL-1:0] acc_o
);

  logic [`CGRA_N_COL-1:0] cell_load;

  for (genvar c = 0; c < `CGRA_N_COL; c++) begin : gen_col
    // Column 0 wraps round to the last column
    localparam int unsigned LeftCol = (c + `CGRA_N_COL - 1) % `CGRA_N_COL;

    assign cell_load[c] = acc_we_i && (acc_col_i == col_idx_t'(c));

    reconfigurable_cell rc_inst (
      .clk_i       ( clk_i          ),
      .rst_ni      ( rst_ni         ),
      .instr_i     ( line_i[c]      ),
      .exec_en_i   ( exec_en_i      ),
      .nbr_acc_i   ( acc_o[LeftCol] ),
      .load_i      ( cell_load[c]   ),
      .load_data_i ( acc_wdata_i    ),
      .acc_o       ( acc_o[c]       )
    );
  end

endmodule

//--- rtl/cgra_top.sv
// ------------------------------------------------------------
// CGRA subsystem top: host register port, context memory port
// and the end-of-kernel event, around a 4-column cell array
// ------------------------------------------------------------
`timescale 1ns/10ps
`include "cgra_cfg.svh"

module cgra_top
  import cgra_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Host register port
  input  reg_req_t  reg_req_i,
  output reg_rsp_t  reg_rsp_o,
  // Context memory host port
  input  logic      cm_req_i,
  input  logic      cm_we_i,
  input  cm_addr_t  cm_add_i,
  input  ctx_word_t cm_wdata_i,
  output logic      cm_gnt_o,
  output logic      cm_rvalid_o,
  output ctx_word_t cm_rdata_o,
  // End of kernel
  output logic      evt_o
);

  logic                           start_s;
  line_idx_t                      start_line_s;
  logic                           busy_s;
  logic                           done_s;
  dp_word_t [`CGRA_N_COL-1:0]     acc_s;
  logic                           acc_we_s;
  col_idx_t                       acc_col_s;
  dp_word_t                       acc_wdata_s;
  logic                           cnt_load_s;
  line_idx_t                      cnt_line_s;
  logic                           cnt_adv_s;
  line_idx_t                      pc_line_s;
  logic                           last_line_s;
  logic                           line_re_s;
  ctx_line_t                      ctx_line_s;
  logic                           exec_en_s;

  // ------------------------------------------------------------
  // Control path
  // ------------------------------------------------------------

  cgra_synchronizer synchronizer_inst (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .reg_req_i    ( reg_req_i    ),
    .reg_rsp_o    ( reg_rsp_o    ),
    .busy_i       ( busy_s       ),
    .done_i       ( done_s       ),
    .acc_i        ( acc_s        ),
    .start_o      ( start_s      ),
    .start_line_o ( start_line_s ),
    .acc_we_o     ( acc_we_s     ),
    .acc_col_o    ( acc_col_s    ),
    .acc_wdata_o  ( acc_wdata_s  ),
    .evt_o        ( evt_o        )
  );

  cgra_controller controller_inst (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .start_i      ( start_s      ),
    .start_line_i ( start_line_s ),
    .line_i       ( ctx_line_s   ),
    .last_line_i  ( last_line_s  ),
    .cnt_load_o   ( cnt_load_s   ),
    .cnt_line_o   ( cnt_line_s   ),
    .cnt_adv_o    ( cnt_adv_s    ),
    .line_re_o    ( line_re_s    ),
    .exec_en_o    ( exec_en_s    ),
    .busy_o       ( busy_s       ),
    .done_o       ( done_s       )
  );

  cgra_pc_counter pc_counter_inst (
    .clk_i  ( clk_i       ),
    .rst_ni ( rst_ni      ),
    .load_i ( cnt_load_s  ),
    .line_i ( cnt_line_s  ),
    .adv_i  ( cnt_adv_s   ),
    .line_o ( pc_line_s   ),
    .last_o ( last_line_s )
  );

  // ------------------------------------------------------------
  // Storage and datapath
  // ------------------------------------------------------------

  context_memory_decoder cmem_inst (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .cm_req_i    ( cm_req_i    ),
    .cm_we_i     ( cm_we_i     ),
    .cm_add_i    ( cm_add_i    ),
    .cm_wdata_i  ( cm_wdata_i  ),
    .cm_gnt_o    ( cm_gnt_o    ),
    .cm_rvalid_o ( cm_rvalid_o ),
    .cm_rdata_o  ( cm_rdata_o  ),
    .busy_i      ( busy_s      ),
    .line_re_i   ( line_re_s   ),
    .line_addr_i ( pc_line_s   ),
    .line_o      ( ctx_line_s  )
  );

  cgra_rcs rcs_inst (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .line_i      ( ctx_line_s  ),
    .exec_en_i   ( exec_en_s   ),
    .acc_we_i    ( acc_we_s    ),
    .acc_col_i   ( acc_col_s   ),
    .acc_wdata_i ( acc_wdata_s ),
    .acc_o       ( acc_s       )
  );

endmodule

//--- sim/cgra_top_chk.sv
// ------------------------------------------------------------
// Protocol and state checks bound into the CGRA top level
// ------------------------------------------------------------
`timescale 1ns/10ps

module cgra_top_chk
  import cgra_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        evt_i,
  input logic        busy_i,
  input logic        gnt_i,
  input logic        we_i,
  input logic        rvalid_i,
  input logic        exec_en_i,
  input ctrl_state_e state_i
);

  // Number of assertion failures so far
  int unsigned fail_cnt = 0;

  evt_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evt_i |=> !evt_i) else begin
    $error("evt_o held for more than one cycle");
    fail_cnt++;
  end

  gnt_low_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_i |-> !gnt_i) else begin
    $error("cm_gnt_o high while a kernel is busy");
    fail_cnt++;
  end

  exec_only_in_exec: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exec_en_i |-> state_i == CTRL_EXEC) else begin
    $error("exec_en high outside EXEC");
    fail_cnt++;
  end

  // Read data valid exactly one cycle after a granted read
  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_i && !we_i) |=> rvalid_i) else begin
    $error("cm_rvalid_o missing after a read");
    fail_cnt++;
  end

  rvalid_only_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(gnt_i && !we_i) |=> !rvalid_i) else begin
    $error("cm_rvalid_o without a read");
    fail_cnt++;
  end

endmodule

bind cgra_top cgra_top_chk chk_inst (
  .clk_i     ( clk_i                   ),
  .rst_ni    ( rst_ni                  ),
  .evt_i     ( evt_o                   ),
  .busy_i    ( busy_s                  ),
  .gnt_i     ( cm_gnt_o                ),
  .we_i      ( cm_we_i                 ),
  .rvalid_i  ( cm_rvalid_o             ),
  .exec_en_i ( exec_en_s               ),
  .state_i   ( controller_inst.state_q )
);

//--- sim/tb_cgra_top.sv
// ------------------------------------------------------------
// Testbench for the CGRA top: register and context memory
// access, then a table of kernels checked against a cell model
// ------------------------------------------------------------
`timescale 1ns/10ps
`include "cgra_cfg.svh"

module tb_cgra_top;
  import cgra_pkg::*;

  localparam int NumEntries    = 5;
  localparam int TimeoutCycles = 40 * NumEntries + 200;

  logic      clk_i;
  logic      rst_ni;
  reg_req_t  reg_req_i;
  reg_rsp_t  reg_rsp_o;
  logic      cm_req_i;
  logic      cm_we_i;
  cm_addr_t  cm_add_i;
  ctx_word_t cm_wdata_i;
  logic      cm_gnt_o;
  logic      cm_rvalid_o;
  ctx_word_t cm_rdata_o;
  logic      evt_o;

  integer seed = 65310;
  int     cycle_cnt = 0;
  int     evt_count = 0;
  int     evt_cycle = 0;
  int     accept_cycle = 0;

  // ------------------------------------------------------------
  // Kernel table
  // ------------------------------------------------------------
  ctx_line_t                  prog       [NumEntries][`CGRA_N_LINES];
  line_idx_t                  start_line [NumEntries];
  int                         prog_len   [NumEntries];
  int                         late_col   [NumEntries];
  dp_word_t                   late_val   [NumEntries];
  dp_word_t [`CGRA_N_COL-1:0] init_acc   [NumEntries];
  dp_word_t [`CGRA_N_COL-1:0] exp_acc    [NumEntries];
  int                         exp_lines  [NumEntries];

  cgra_top cgra_top_inst (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .reg_req_i   ( reg_req_i   ),
    .reg_rsp_o   ( reg_rsp_o   ),
    .cm_req_i    ( cm_req_i    ),
    .cm_we_i     ( cm_we_i     ),
    .cm_add_i    ( cm_add_i    ),
    .cm_wdata_i  ( cm_wdata_i  ),
    .cm_gnt_o    ( cm_gnt_o    ),
    .cm_rvalid_o ( cm_rvalid_o ),
    .cm_rdata_o  ( cm_rdata_o  ),
    .evt_o       ( evt_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("ERROR: run did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  // Event pulses counted mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni && evt_o) begin
      evt_count = evt_count + 1;
      evt_cycle = cycle_cnt;
    end
  end

  // ------------------------------------------------------------
  // Checks and host access
  // ------------------------------------------------------------
  task automatic expect_equal(input string name, input dp_word_t exp_v, input dp_word_t act_v);
    assert (act_v === exp_v) else begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR at %0t ns: %s", $time, what);
      $display("Simulation FAILED");
      $fatal(1, "condition failed");
    end
  endtask

  // Bound protocol assertions end the run at their first failure
  always @(negedge clk_i) begin
    expect_true(cgra_top_inst.chk_inst.fail_cnt == 0, "bound protocol assertion failed");
  end

  function automatic reg_addr_t acc_addr(input int c);
    return reg_addr_t'(`CGRA_REG_ACC_BASE + c);
  endfunction

  task automatic write_reg(input reg_addr_t addr, input dp_word_t data, output int stalls);
    stalls = 0;
    reg_req_i.valid = 1'b1;
    reg_req_i.write = 1'b1;
    reg_req_i.addr  = addr;
    reg_req_i.wdata = data;
    @(negedge clk_i);
    while (!reg_rsp_o.ready) begin
      stalls++;
      @(negedge clk_i);
    end
    accept_cycle = cycle_cnt;
    @(posedge clk_i);
    #10;
    reg_req_i = '0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output dp_word_t data);
    reg_req_i.valid = 1'b1;
    reg_req_i.write = 1'b0;
    reg_req_i.addr  = addr;
    reg_req_i.wdata = '0;
    @(negedge clk_i);
    data = reg_rsp_o.rdata;
    @(posedge clk_i);
    #10;
    reg_req_i = '0;
  endtask

  task automatic write_ctx_word(input cm_addr_t addr, input ctx_word_t data);
    cm_req_i   = 1'b1;
    cm_we_i    = 1'b1;
    cm_add_i   = addr;
    cm_wdata_i = data;
    @(negedge clk_i);
    while (!cm_gnt_o) @(negedge clk_i);
    @(posedge clk_i);
    #10;
    cm_req_i = 1'b0;
    cm_we_i  = 1'b0;
  endtask

  task automatic read_ctx_word(input cm_addr_t addr, output ctx_word_t data);
    cm_req_i = 1'b1;
    cm_we_i  = 1'b0;
    cm_add_i = addr;
    @(negedge clk_i);
    while (!cm_gnt_o) @(negedge clk_i);
    @(posedge clk_i);
    #10;
    cm_req_i = 1'b0;
    @(negedge clk_i);
    expect_equal("cm_rvalid_o", 1, cm_rvalid_o);
    data = cm_rdata_o;
    @(posedge clk_i);
    #10;
  endtask

  // ------------------------------------------------------------
  // Cell model
  // ------------------------------------------------------------
  function automatic dp_word_t cell_result(input ctx_word_t w, input dp_word_t acc,
                                           input dp_word_t left);
    logic [2:0] op;
    dp_word_t   imm;
    op  = w[`CGRA_IMM_WIDTH +: 3];
    imm = dp_word_t'(w[`CGRA_IMM_WIDTH-1:0]);
    case (op)
      RC_LDI:  return imm;
      RC_ADDI: return acc + imm;
      RC_SUBI: return acc - imm;
      RC_MULI: return acc * imm;
      RC_SHLI: return acc << imm[4:0];
      RC_ADDN: return acc + left;
      default: return acc;
    endcase
  endfunction

  task automatic model_kernel(input int e);
    dp_word_t [`CGRA_N_COL-1:0] acc;
    dp_word_t [`CGRA_N_COL-1:0] nxt;
    int                         l;
    acc = init_acc[e];
    exp_lines[e] = 0;
    l = start_line[e];
    // Stops on a column-0 END or after the last memory line
    while (l < `CGRA_N_LINES && prog[e][l][0][`CGRA_IMM_WIDTH +: 3] != RC_END) begin
      for (int c = 0; c < `CGRA_N_COL; c++) begin
        nxt[c] = cell_result(prog[e][l][c], acc[c], acc[(c + `CGRA_N_COL - 1) % `CGRA_N_COL]);
      end
      acc = nxt;
      exp_lines[e]++;
      l++;
    end
    // Stalled host write lands once the kernel is over
    if (late_col[e] >= 0) begin
      acc[late_col[e]] = late_val[e];
    end
    exp_acc[e] = acc;
  endtask

  task automatic set_line(input int e, input int l, input rc_op_e op0, input rc_op_e op1,
                          input rc_op_e op2, input rc_op_e op3);
    prog[e][l][0] = {op0, imm_t'($random(seed))};
    prog[e][l][1] = {op1, imm_t'($random(seed))};
    prog[e][l][2] = {op2, imm_t'($random(seed))};
    prog[e][l][3] = {op3, imm_t'($random(seed))};
  endtask

  task automatic build_table();
    for (int e = 0; e < NumEntries; e++) begin
      for (int c = 0; c < `CGRA_N_COL; c++) init_acc[e][c] = $random(seed);
      late_col[e] = -1;
      late_val[e] = $random(seed);
    end
    // All arithmetic ops, then a full ADDN ring
    start_line[0] = 0;
    prog_len[0]   = 4;
    set_line(0, 0, RC_LDI, RC_LDI, RC_LDI, RC_LDI);
    set_line(0, 1, RC_ADDI, RC_SUBI, RC_MULI, RC_SHLI);
    set_line(0, 2, RC_ADDN, RC_ADDN, RC_ADDN, RC_ADDN);
    set_line(0, 3, RC_END, RC_LDI, RC_LDI, RC_LDI);
    // Nonzero start; END outside column 0 does nothing
    start_line[1] = 5;
    prog_len[1]   = 5;
    set_line(1, 5, RC_NOP, RC_ADDN, RC_SUBI, RC_END);
    set_line(1, 6, RC_MULI, RC_SHLI, RC_ADDN, RC_ADDI);
    set_line(1, 7, RC_ADDN, RC_NOP, RC_LDI, RC_MULI);
    set_line(1, 8, RC_SUBI, RC_ADDI, RC_SHLI, RC_ADDN);
    set_line(1, 9, RC_END, RC_ADDI, RC_ADDI, RC_ADDI);
    start_line[2] = 2;
    prog_len[2]   = 3;
    set_line(2, 2, RC_SHLI, RC_MULI, RC_ADDN, RC_SUBI);
    set_line(2, 3, RC_ADDN, RC_ADDN, RC_ADDN, RC_ADDN);
    set_line(2, 4, RC_END, RC_NOP, RC_NOP, RC_NOP);
    // No END at all, runs off line 15
    start_line[3] = 10;
    prog_len[3]   = 6;
    for (int l = 10; l < `CGRA_N_LINES; l++) begin
      set_line(3, l, rc_op_e'(l % 6 + 1), rc_op_e'((l + 1) % 6 + 1),
               rc_op_e'((l + 2) % 6 + 1), rc_op_e'((l + 3) % 6 + 1));
    end
    // Host write issued while this kernel runs
    start_line[4] = 1;
    prog_len[4]   = 4;
    late_col[4]   = 2;
    set_line(4, 1, RC_LDI, RC_ADDI, RC_SUBI, RC_MULI);
    set_line(4, 2, RC_ADDN, RC_ADDN, RC_ADDN, RC_ADDN);
    set_line(4, 3, RC_SHLI, RC_NOP, RC_ADDN, RC_LDI);
    set_line(4, 4, RC_END, RC_SUBI, RC_SUBI, RC_SUBI);
    for (int e = 0; e < NumEntries; e++) model_kernel(e);
  endtask

  // ------------------------------------------------------------
  // One table entry
  // ------------------------------------------------------------
  task automatic run_entry(input int e);
    int       l;
    int       stalls;
    int       base_evt;
    int       start_cycle;
    dp_word_t rd;
    for (int i = 0; i < prog_len[e]; i++) begin
      l = start_line[e] + i;
      for (int c = 0; c < `CGRA_N_COL; c++) begin
        write_ctx_word(cm_addr_t'({line_idx_t'(l), col_idx_t'(c)}), prog[e][l][c]);
      end
    end
    for (int c = 0; c < `CGRA_N_COL; c++) write_reg(acc_addr(c), init_acc[e][c], stalls);
    base_evt = evt_count;
    write_reg(reg_addr_t'(`CGRA_REG_CTRL), (dp_word_t'(start_line[e]) << 4) | 32'd1, stalls);
    start_cycle = accept_cycle;
    // Host memory access is refused while the kernel runs
    cm_req_i = 1'b1;
    cm_we_i  = 1'b0;
    cm_add_i = '0;
    @(negedge clk_i);
    expect_equal("cm_gnt_o", 0, cm_gnt_o);
    @(posedge clk_i);
    #10;
    cm_req_i = 1'b0;
    if (late_col[e] >= 0) begin
      write_reg(acc_addr(late_col[e]), late_val[e], stalls);
      expect_true(stalls > 0, "accumulator write during a kernel was not held off");
    end
    while (evt_count == base_evt) begin
      @(posedge clk_i);
      #10;
    end
    expect_equal("evt_o latency", exp_lines[e] + 3, evt_cycle - start_cycle);
    read_reg(reg_addr_t'(`CGRA_REG_STATUS), rd);
    expect_equal("STATUS", 32'h2, rd);
    for (int c = 0; c < `CGRA_N_COL; c++) begin
      read_reg(acc_addr(c), rd);
      expect_equal($sformatf("entry %0d acc[%0d]", e, c), exp_acc[e][c], rd);
    end
    expect_equal("evt_o pulse count", 1, evt_count - base_evt);
  endtask

  initial begin
    dp_word_t  rd;
    dp_word_t  wv;
    ctx_word_t cw;
    ctx_word_t words [8];
    int        stalls;
    rst_ni     = 1'b0;
    reg_req_i  = '0;
    cm_req_i   = 1'b0;
    cm_we_i    = 1'b0;
    cm_add_i   = '0;
    cm_wdata_i = '0;
    build_table();
    repeat (4) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    // Reset state and accumulator write/read
    read_reg(reg_addr_t'(`CGRA_REG_STATUS), rd);
    expect_equal("STATUS", 0, rd);
    for (int c = 0; c < `CGRA_N_COL; c++) begin
      read_reg(acc_addr(c), rd);
      expect_equal($sformatf("acc[%0d] after reset", c), 0, rd);
    end
    for (int c = 0; c < `CGRA_N_COL; c++) begin
      wv = $random(seed);
      write_reg(acc_addr(c), wv, stalls);
      read_reg(acc_addr(c), rd);
      expect_equal($sformatf("acc[%0d]", c), wv, rd);
    end

    // Context words through the host port
    for (int i = 0; i < 8; i++) begin
      words[i] = ctx_word_t'($random(seed));
      write_ctx_word(cm_addr_t'(i * 9), words[i]);
    end
    for (int i = 0; i < 8; i++) begin
      read_ctx_word(cm_addr_t'(i * 9), cw);
      expect_equal($sformatf("cm_rdata_o word %0d", i), words[i], cw);
    end

    for (int e = 0; e < NumEntries; e++) run_entry(e);

    expect_true(cgra_top_inst.chk_inst.fail_cnt == 0, "bound protocol assertion failed");
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+common
common/cgra_pkg.sv
rtl/cgra_pc_counter.sv
rtl/cgra_controller.sv
rtl/cgra_synchronizer.sv
rtl/context_memory/context_memory_decoder.sv
rtl/cgra_rcs/reconfigurable_cell.sv
rtl/cgra_rcs/cgra_rcs.sv
rtl/cgra_top.sv
sim/cgra_top_chk.sv
sim/tb_cgra_top.sv
